// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search, not from the simulator exit code
sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
design/cpu_pkg.sv
design/alu.sv
design/reg_file.sv
design/operand_fetch.sv
design/execute_stage.sv
design/cpu_core.sv
testbench/clock_gen.sv
testbench/tb_cpu_core.sv

// ==== design/alu.sv ====
module alu #(
   parameter int data_width = 8
) (
   input  cpu_pkg::opcode_t        op,
   input  logic [data_width-1:0]   a,
   input  logic [data_width-1:0]   b,
   input  cpu_pkg::flags_t         flags_in,
   output logic [data_width-1:0]   result,
   output cpu_pkg::flags_t         flags_out
);
   import cpu_pkg::*;

   logic                    carry_in;
   logic [data_width-1:0]   add_b;
   logic [data_width-1:0]   sum;
   logic                    carry_out;
   logic                    overflow;
   logic [2*data_width-1:0] product;

   // adder second operand and carry-in
   always_comb begin
      add_b    = b;
      carry_in = 1'b0;
      case (op)
         op_adc: begin
            carry_in = flags_in.c;
         end
         op_sub, op_cmp: begin
            add_b    = ~b;
            carry_in = 1'b1;
         end
         op_sbb: begin
            add_b    = ~b;
            carry_in = flags_in.c;
         end
         op_inc: begin
            add_b    = '0;
            carry_in = 1'b1;
         end
         op_dec: begin
            add_b    = '1;
            carry_in = 1'b0;
         end
         default: begin
            add_b    = b;
            carry_in = 1'b0;
         end
      endcase
   end

   assign {carry_out, sum} = {1'b0, a} + {1'b0, add_b} + (data_width + 1)'(carry_in);

   // signed overflow of the adder
   assign overflow = (a[data_width-1] == add_b[data_width-1]) &&
                     (sum[data_width-1] != a[data_width-1]);

   assign product = (2 * data_width)'(a) * (2 * data_width)'(b);

   always_comb begin
      result    = b;
      flags_out = flags_in;
      case (op)
         op_add, op_adc, op_sub, op_sbb, op_inc, op_dec, op_cmp: begin
            result      = sum;
            flags_out.c = carry_out;
            flags_out.v = overflow;
            flags_out.s = sum[data_width-1];
         end
         op_and: result = a & b;
         op_or:  result = a | b;
         op_xor: result = a ^ b;
         op_shl: begin
            result      = {a[data_width-2:0], 1'b0};
            flags_out.c = a[data_width-1];
         end
         op_shr: begin
            result      = {1'b0, a[data_width-1:1]};
            flags_out.c = a[0];
         end
         op_sha: begin
            result      = {a[data_width-1], a[data_width-1:1]};
            flags_out.c = a[0];
         end
         // rotates go through the carry
         op_rol: begin
            result      = {a[data_width-2:0], flags_in.c};
            flags_out.c = a[data_width-1];
         end
         op_ror: begin
            result      = {flags_in.c, a[data_width-1:1]};
            flags_out.c = a[0];
         end
         op_mul: begin
            result      = product[data_width-1:0];
            flags_out.s = product[data_width-1];
         end
         op_muh: begin
            result      = product[2*data_width-1:data_width];
            flags_out.s = product[2*data_width-1];
         end
         op_stc: flags_out.c = 1'b1;
         op_clc: flags_out.c = 1'b0;
         default: result = b;
      endcase

      // zero follows the result except for the carry ops
      if (!(op inside {op_stc, op_clc})) begin
         flags_out.z = ~|result;
      end
   end

endmodule

// ==== design/cpu_core.sv ====
module cpu_core #(
   parameter int data_width = 8
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  in_valid,
   input  cpu_pkg::instr_t       in_instr,
   output logic                  out_valid,
   output cpu_pkg::reg_idx_t     out_rd,
   output logic [data_width-1:0] out_data,
   output logic                  out_write,
   output cpu_pkg::flags_t       out_flags
);
   import cpu_pkg::*;

   reg_idx_t              rd_a_idx;
   reg_idx_t              rd_b_idx;
   logic [data_width-1:0] rd_a_data;
   logic [data_width-1:0] rd_b_data;
   wb_ctl_t               wb_ctl;
   logic [data_width-1:0] wb_data;

   // issue bundle
   logic                  iss_valid;
   opcode_t               iss_op;
   reg_idx_t              iss_rd;
   logic [data_width-1:0] iss_a;
   logic [data_width-1:0] iss_b;

   operand_fetch #(
      .data_width(data_width)
   ) i_fetch (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .in_instr  (in_instr),
      .rd_a_idx  (rd_a_idx),
      .rd_b_idx  (rd_b_idx),
      .rd_a_data (rd_a_data),
      .rd_b_data (rd_b_data),
      .wb_ctl    (wb_ctl),
      .wb_data   (wb_data),
      .iss_valid (iss_valid),
      .iss_op    (iss_op),
      .iss_rd    (iss_rd),
      .iss_a     (iss_a),
      .iss_b     (iss_b)
   );

   reg_file #(
      .data_width(data_width)
   ) i_regs (
      .clk       (clk),
      .reset     (reset),
      .rd_a_idx  (rd_a_idx),
      .rd_b_idx  (rd_b_idx),
      .rd_a_data (rd_a_data),
      .rd_b_data (rd_b_data),
      .wb_ctl    (wb_ctl),
      .wb_data   (wb_data)
   );

   execute_stage #(
      .data_width(data_width)
   ) i_exec (
      .clk       (clk),
      .reset     (reset),
      .iss_valid (iss_valid),
      .iss_op    (iss_op),
      .iss_rd    (iss_rd),
      .iss_a     (iss_a),
      .iss_b     (iss_b),
      .wb_ctl    (wb_ctl),
      .wb_data   (wb_data),
      .out_valid (out_valid),
      .out_rd    (out_rd),
      .out_data  (out_data),
      .out_write (out_write),
      .out_flags (out_flags)
   );

endmodule

// ==== design/cpu_pkg.sv ====
package cpu_pkg;

   // unlisted codes act as mov
   typedef enum logic [4:0] {
      op_add = 5'd0,
      op_adc = 5'd1,
      op_sub = 5'd2,
      op_sbb = 5'd3,
      op_inc = 5'd4,
      op_dec = 5'd5,
      op_and = 5'd6,
      op_or  = 5'd7,
      op_xor = 5'd8,
      op_shl = 5'd9,
      op_shr = 5'd10,
      op_rol = 5'd11,
      op_ror = 5'd12,
      op_mul = 5'd13,
      op_mov = 5'd14,
      op_cmp = 5'd15,
      op_sha = 5'd16,
      op_stc = 5'd17,
      op_clc = 5'd18,
      op_muh = 5'd19
   } opcode_t;

   typedef logic [2:0] reg_idx_t;

   // immediates are zero-extended to the data width
   localparam int imm_w = 8;

   // second source as a register index
   typedef struct packed {
      reg_idx_t   rb;
      logic [7:0] rsvd;
   } reg_form_t;

   // second source as an immediate
   typedef struct packed {
      logic [imm_w-1:0] imm;
      logic [2:0]       rsvd;
   } imm_form_t;

   // use_imm picks the form of these 11 bits
   typedef union packed {
      reg_form_t reg_form;
      imm_form_t imm_form;
   } operand_u;

   typedef struct packed {
      opcode_t  op;
      logic     use_imm;
      reg_idx_t rd;
      reg_idx_t ra;
      operand_u operand;
   } instr_t;

   typedef struct packed {
      logic c;
      logic v;
      logic z;
      logic s;
   } flags_t;

   // write data travels beside this control
   typedef struct packed {
      logic     valid;
      reg_idx_t rd;
      logic     rsvd;
   } wb_ctl_t;

endpackage

// ==== design/execute_stage.sv ====
module execute_stage #(
   parameter int data_width = 8
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  iss_valid,
   input  cpu_pkg::opcode_t      iss_op,
   input  cpu_pkg::reg_idx_t     iss_rd,
   input  logic [data_width-1:0] iss_a,
   input  logic [data_width-1:0] iss_b,
   output cpu_pkg::wb_ctl_t      wb_ctl,
   output logic [data_width-1:0] wb_data,
   output logic                  out_valid,
   output cpu_pkg::reg_idx_t     out_rd,
   output logic [data_width-1:0] out_data,
   output logic                  out_write,
   output cpu_pkg::flags_t       out_flags
);
   import cpu_pkg::*;

   logic [data_width-1:0] alu_result;
   flags_t                alu_flags;
   flags_t                flags_q;
   logic                  write_en;
   logic [data_width-1:0] result_q;

   alu #(
      .data_width(data_width)
   ) i_alu (
      .op        (iss_op),
      .a         (iss_a),
      .b         (iss_b),
      .flags_in  (flags_q),
      .result    (alu_result),
      .flags_out (alu_flags)
   );

   // compare and carry ops only touch the flags
   assign write_en = !(iss_op inside {op_cmp, op_stc, op_clc});

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
         wb_ctl    <= '0;
         flags_q   <= '0;
      end else begin
         out_valid    <= iss_valid;
         wb_ctl.valid <= iss_valid && write_en;
         wb_ctl.rd    <= iss_rd;
         wb_ctl.rsvd  <= 1'b0;
         if (iss_valid) begin
            flags_q <= alu_flags;
         end
      end
   end

   always_ff @(posedge clk) begin
      result_q  <= alu_result;
      out_write <= write_en;
   end

   assign wb_data   = result_q;
   assign out_data  = result_q;
   assign out_rd    = wb_ctl.rd;
   assign out_flags = flags_q;

endmodule

// ==== design/operand_fetch.sv ====
module operand_fetch #(
   parameter int data_width = 8
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  in_valid,
   input  cpu_pkg::instr_t       in_instr,
   output cpu_pkg::reg_idx_t     rd_a_idx,
   output cpu_pkg::reg_idx_t     rd_b_idx,
   input  logic [data_width-1:0] rd_a_data,
   input  logic [data_width-1:0] rd_b_data,
   input  cpu_pkg::wb_ctl_t      wb_ctl,
   input  logic [data_width-1:0] wb_data,
   output logic                  iss_valid,
   output cpu_pkg::opcode_t      iss_op,
   output cpu_pkg::reg_idx_t     iss_rd,
   output logic [data_width-1:0] iss_a,
   output logic [data_width-1:0] iss_b
);
   import cpu_pkg::*;

   logic                  b_is_reg;
   logic [data_width-1:0] src_a;
   logic [data_width-1:0] src_b;

   // issue stage payload
   logic [data_width-1:0] a_q;
   logic [data_width-1:0] b_q;
   reg_idx_t              ra_q;
   reg_idx_t              rb_q;
   logic                  b_reg_q;

   assign rd_a_idx = in_instr.ra;
   assign rd_b_idx = in_instr.operand.reg_form.rb;
   assign b_is_reg = !in_instr.use_imm;

   // write-back two ahead is not in the register file yet
   always_comb begin
      src_a = rd_a_data;
      if (wb_ctl.valid && wb_ctl.rd == rd_a_idx) begin
         src_a = wb_data;
      end
      if (b_is_reg) begin
         src_b = rd_b_data;
         if (wb_ctl.valid && wb_ctl.rd == rd_b_idx) begin
            src_b = wb_data;
         end
      end else begin
         src_b = data_width'(in_instr.operand.imm_form.imm);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         iss_valid <= 1'b0;
      end else begin
         iss_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      iss_op  <= in_instr.op;
      iss_rd  <= in_instr.rd;
      a_q     <= src_a;
      b_q     <= src_b;
      ra_q    <= rd_a_idx;
      rb_q    <= rd_b_idx;
      b_reg_q <= b_is_reg;
   end

   // producer directly ahead writes back while this one sits in issue
   assign iss_a = (wb_ctl.valid && wb_ctl.rd == ra_q) ? wb_data : a_q;
   assign iss_b = (b_reg_q && wb_ctl.valid && wb_ctl.rd == rb_q) ? wb_data : b_q;

endmodule

// ==== design/reg_file.sv ====
module reg_file #(
   parameter int data_width = 8
) (
   input  logic                  clk,
   input  logic                  reset,
   input  cpu_pkg::reg_idx_t     rd_a_idx,
   input  cpu_pkg::reg_idx_t     rd_b_idx,
   output logic [data_width-1:0] rd_a_data,
   output logic [data_width-1:0] rd_b_data,
   input  cpu_pkg::wb_ctl_t      wb_ctl,
   input  logic [data_width-1:0] wb_data
);
   import cpu_pkg::*;

   localparam int num_regs = 2 ** $bits(reg_idx_t);

   logic [data_width-1:0] regs [num_regs];

   // reads see a write in the cycle after its edge
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_ctl.valid) begin
         regs[wb_ctl.rd] <= wb_data;
      end
   end

   assign rd_a_data = regs[rd_a_idx];
   assign rd_b_data = regs[rd_b_idx];

endmodule

// ==== testbench/clock_gen.sv ====
module clock_gen (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // released just after the fifth rising edge
   initial begin
      reset = 1'b1;
      repeat (5) @(posedge clk);
      #1 reset = 1'b0;
   end

endmodule

// ==== testbench/tb_cpu_core.sv ====
module tb_cpu_core;
   import cpu_pkg::*;

   localparam int dw = 8;
   localparam int s_max = (1 << (dw - 1)) - 1;
   localparam int s_min = -(1 << (dw - 1));
   localparam int wait_limit = 50;

   typedef struct packed {
      logic [dw-1:0] data;
      flags_t        flags;
   } alu_out_t;

   typedef struct packed {
      logic [31:0]   due;
      reg_idx_t      rd;
      logic [dw-1:0] data;
      logic          write;
      flags_t        flags;
   } expect_t;

   logic          clk;
   logic          reset;
   logic          in_valid;
   instr_t        in_instr;
   logic          out_valid;
   reg_idx_t      out_rd;
   logic [dw-1:0] out_data;
   logic          out_write;
   flags_t        out_flags;

   // model state follows issue order
   logic [dw-1:0] regs_m [8];
   flags_t        flags_m;
   expect_t       exp_q [$];
   logic [31:0]   lfsr_state = 32'hd64763ad;
   int            cycle = 0;

   clock_gen i_clk (
      .clk   (clk),
      .reset (reset)
   );

   cpu_core #(
      .data_width(dw)
   ) i_dut (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .in_instr  (in_instr),
      .out_valid (out_valid),
      .out_rd    (out_rd),
      .out_data  (out_data),
      .out_write (out_write),
      .out_flags (out_flags)
   );

   always @(posedge clk) cycle <= cycle + 1;

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
      if (got !== want) begin
         $display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
         fail_run("mismatch on DUT output");
      end
   endtask

   // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_step(lfsr_state);
      end
      return v;
   endfunction

   function automatic int as_signed(input logic [dw-1:0] x);
      return x[dw-1] ? int'(x) - (1 << dw) : int'(x);
   endfunction

   function automatic alu_out_t ref_alu(input opcode_t op, input logic [dw-1:0] a,
                                        input logic [dw-1:0] b, input flags_t fin);
      alu_out_t        o;
      logic [dw-1:0]   opnd;
      logic            cin;
      logic [dw:0]     wide;
      logic [2*dw-1:0] prod;
      int              sr;
      o.data  = b;
      o.flags = fin;
      prod    = {{dw{1'b0}}, a} * {{dw{1'b0}}, b};
      case (op)
         op_add, op_adc, op_sub, op_sbb, op_inc, op_dec, op_cmp: begin
            opnd = (op inside {op_sub, op_sbb, op_cmp}) ? ~b : b;
            cin  = (op inside {op_sub, op_cmp, op_inc});
            if (op inside {op_adc, op_sbb}) cin = fin.c;
            if (op == op_inc) opnd = '0;
            if (op == op_dec) opnd = '1;
            wide      = {1'b0, a} + {1'b0, opnd} + {{dw{1'b0}}, cin};
            sr        = as_signed(a) + as_signed(opnd) + int'(cin);
            o.data    = wide[dw-1:0];
            o.flags.c = wide[dw];
            o.flags.v = (sr > s_max) || (sr < s_min);
            o.flags.s = o.data[dw-1];
         end
         op_and: o.data = a & b;
         op_or:  o.data = a | b;
         op_xor: o.data = a ^ b;
         op_shl: {o.flags.c, o.data} = {a, 1'b0};
         op_shr: {o.data, o.flags.c} = {1'b0, a};
         op_sha: {o.data, o.flags.c} = {a[dw-1], a};
         op_rol: {o.flags.c, o.data} = {a, fin.c};
         op_ror: {o.data, o.flags.c} = {fin.c, a};
         op_mul: o.data = prod[dw-1:0];
         op_muh: o.data = prod[2*dw-1:dw];
         op_stc: o.flags.c = 1'b1;
         op_clc: o.flags.c = 1'b0;
         default: o.data = b;
      endcase
      if (op inside {op_mul, op_muh}) o.flags.s = o.data[dw-1];
      if (!(op inside {op_stc, op_clc})) o.flags.z = (o.data == '0);
      return o;
   endfunction

   function automatic instr_t reg_instr(input opcode_t op, input reg_idx_t rd,
                                        input reg_idx_t ra, input reg_idx_t rb);
      instr_t ins;
      ins = '0;
      ins.op = op;
      ins.rd = rd;
      ins.ra = ra;
      ins.operand.reg_form.rb = rb;
      return ins;
   endfunction

   function automatic instr_t imm_instr(input opcode_t op, input reg_idx_t rd,
                                        input reg_idx_t ra, input logic [7:0] imm);
      instr_t ins;
      ins = '0;
      ins.op = op;
      ins.use_imm = 1'b1;
      ins.rd = rd;
      ins.ra = ra;
      ins.operand.imm_form.imm = imm;
      return ins;
   endfunction

   // called at the drive point, returns at the next one
   task automatic send(input instr_t ins);
      logic [dw-1:0] a_v;
      logic [dw-1:0] b_v;
      alu_out_t      r;
      expect_t       e;
      a_v = regs_m[ins.ra];
      b_v = ins.use_imm ? dw'(ins.operand.imm_form.imm) : regs_m[ins.operand.reg_form.rb];
      r = ref_alu(ins.op, a_v, b_v, flags_m);
      e.due   = cycle + 2;
      e.rd    = ins.rd;
      e.data  = r.data;
      e.write = !(ins.op inside {op_cmp, op_stc, op_clc});
      e.flags = r.flags;
      exp_q.push_back(e);
      flags_m = r.flags;
      if (e.write) regs_m[ins.rd] = r.data;
      in_valid = 1'b1;
      in_instr = ins;
      @(posedge clk);
      #1;
      in_valid = 1'b0;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0) begin
         if (n >= wait_limit) fail_run("results still outstanding after the drain timeout");
         idle(1);
         n++;
      end
   endtask

   always @(negedge clk) begin : compare_proc
      expect_t e;
      if (!reset && out_valid) begin
         if (exp_q.size() == 0) fail_run("out_valid seen with no instruction outstanding");
         e = exp_q.pop_front();
         compare_value("out_valid cycle", 32'(cycle), e.due);
         compare_value("out_rd", 32'(out_rd), 32'(e.rd));
         compare_value("out_write", 32'(out_write), 32'(e.write));
         if (e.write) compare_value("out_data", 32'(out_data), 32'(e.data));
         compare_value("out_flags.c", 32'(out_flags.c), 32'(e.flags.c));
         compare_value("out_flags.v", 32'(out_flags.v), 32'(e.flags.v));
         compare_value("out_flags.z", 32'(out_flags.z), 32'(e.flags.z));
         compare_value("out_flags.s", 32'(out_flags.s), 32'(e.flags.s));
      end
   end

   initial begin : stimulus
      logic [31:0] rnd;
      int          n;
      in_valid = 1'b0;
      in_instr = '0;
      flags_m  = '0;
      for (int i = 0; i < 8; i++) regs_m[i] = '0;
      n = 0;
      @(posedge clk);
      while (reset) begin
         if (n >= wait_limit) fail_run("reset was never released");
         @(posedge clk);
         n++;
      end
      #1;
      // quiet pipeline after reset, then zero registers and clear flags
      repeat (8) begin
         @(negedge clk);
         compare_value("out_valid", 32'(out_valid), 32'd0);
      end
      idle(1);
      send(reg_instr(op_add, 3'd0, 3'd0, 3'd1));
      // arithmetic and carry chains
      send(imm_instr(op_mov, 3'd1, 3'd0, 8'h7f));
      send(imm_instr(op_mov, 3'd2, 3'd0, 8'h01));
      send(imm_instr(op_mov, 3'd3, 3'd0, 8'hff));
      send(reg_instr(op_add, 3'd4, 3'd1, 3'd2));
      send(reg_instr(op_adc, 3'd5, 3'd3, 3'd2));
      send(reg_instr(op_adc, 3'd5, 3'd2, 3'd2));
      send(reg_instr(op_sub, 3'd6, 3'd2, 3'd3));
      send(reg_instr(op_sbb, 3'd6, 3'd6, 3'd2));
      send(reg_instr(op_inc, 3'd7, 3'd1, 3'd0));
      send(reg_instr(op_dec, 3'd7, 3'd7, 3'd0));
      send(reg_instr(op_cmp, 3'd1, 3'd1, 3'd2));
      send(imm_instr(op_or, 3'd0, 3'd1, 8'h00));
      send(imm_instr(op_add, 3'd0, 3'd3, 8'h01));
      idle(3);
      // logic, shifts, rotates through the carry
      send(imm_instr(op_mov, 3'd1, 3'd0, 8'ha5));
      send(imm_instr(op_mov, 3'd2, 3'd0, 8'h3c));
      send(reg_instr(op_and, 3'd3, 3'd1, 3'd2));
      send(reg_instr(op_or, 3'd3, 3'd1, 3'd2));
      send(reg_instr(op_xor, 3'd3, 3'd1, 3'd2));
      send(imm_instr(op_and, 3'd3, 3'd1, 8'h00));
      send(reg_instr(op_shl, 3'd4, 3'd1, 3'd0));
      send(reg_instr(op_shr, 3'd4, 3'd1, 3'd0));
      send(reg_instr(op_sha, 3'd4, 3'd1, 3'd0));
      send(reg_instr(op_stc, 3'd0, 3'd0, 3'd0));
      send(reg_instr(op_rol, 3'd5, 3'd2, 3'd0));
      send(reg_instr(op_clc, 3'd0, 3'd0, 3'd0));
      send(reg_instr(op_ror, 3'd5, 3'd1, 3'd0));
      send(reg_instr(op_stc, 3'd0, 3'd0, 3'd0));
      send(reg_instr(op_ror, 3'd5, 3'd2, 3'd0));
      idle(2);
      // products wider than the data path
      send(imm_instr(op_mov, 3'd1, 3'd0, 8'hc8));
      send(imm_instr(op_mov, 3'd2, 3'd0, 8'h9b));
      send(reg_instr(op_mul, 3'd3, 3'd1, 3'd2));
      send(reg_instr(op_muh, 3'd4, 3'd1, 3'd2));
      send(imm_instr(op_muh, 3'd5, 3'd3, 8'hff));
      idle(2);
      // dependent chain with the producer one and two ahead
      send(imm_instr(op_mov, 3'd1, 3'd0, 8'h03));
      send(reg_instr(op_add, 3'd1, 3'd1, 3'd1));
      send(reg_instr(op_add, 3'd2, 3'd1, 3'd1));
      send(reg_instr(op_sub, 3'd3, 3'd2, 3'd1));
      send(reg_instr(op_xor, 3'd1, 3'd3, 3'd2));
      send(reg_instr(op_inc, 3'd1, 3'd1, 3'd0));
      send(reg_instr(op_mul, 3'd4, 3'd1, 3'd3));
      idle(1);
      send(reg_instr(op_add, 3'd5, 3'd4, 3'd1));
      wait_drain();
      for (int i = 0; i < 400; i++) begin
         send(instr_t'(take_bits($bits(instr_t))));
         rnd = take_bits(3);
         if (rnd > 32'd4) idle(int'(rnd) - 4);
      end
      // read every register back through or with zero
      for (int r = 0; r < 8; r++) send(imm_instr(op_or, 3'(r), 3'(r), 8'h00));
      wait_drain();
      $display("TEST PASSED");
      $finish;
   end

endmodule
